/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sd_cmd
FLIST     = verilog.f
SRCS      = $(shell grep -v '^+' $(FLIST))
BIN       = obj_dir/V$(TOP)
LOG       = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/sd_cmd_asserts.sv */
// ****************************************
// SD command engine protocol assertions
// Bound into the top level
// ****************************************
`timescale 1ns/1ps

module sd_cmd_asserts (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_ready_o,
  input logic sd_cmd_oe_o,
  input logic result_valid_o
);

  // The line is only driven once a request has been taken
  oe_rise_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(sd_cmd_oe_o) |-> !req_ready_o)
    else $error("sd_cmd_oe_o rose while req_ready_o was high");

  result_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result_valid_o |=> !result_valid_o)
    else $error("result_valid_o held for more than one clock");

  ready_after_reset: assert property (@(posedge clk_i)
    !rst_n_i ##1 rst_n_i |-> req_ready_o)
    else $error("req_ready_o low right after reset");

endmodule

bind sd_cmd_top sd_cmd_asserts u_asserts (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .req_ready_o    (req_ready_o),
  .sd_cmd_oe_o    (sd_cmd_oe_o),
  .result_valid_o (result_valid_o)
);

/* sim/tb_sd_cmd.sv */
// ****************************************
// Testbench for the SD command engine
// Card model, reference CRC7 and frames,
// result checking and a run timeout
// ****************************************
`timescale 1ns/1ps

module tb_sd_cmd;

  localparam int MAX_CYCLES = 6000;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic clk_en = 1'b0;
  logic sd_cmd = 1'b1;
  logic busy_n = 1'b1;
  logic req_valid = 1'b0;
  sd_cmd_pkg::sd_cmd_req_t req = '0;

  logic req_ready;
  logic cmd_out;
  logic cmd_oe;
  logic cmd_done;
  logic dat_busy;
  logic result_valid;
  sd_cmd_pkg::sd_cmd_result_t result;

  integer seed = 96843;
  int errors = 0;
  int cycles = 0;
  int done_cnt = 0;
  int issued = 0;

  // Card model controls, set per command
  logic [135:0] card_frame = '0;
  int card_len = 48;
  int card_delay = 4;
  logic card_reply = 1'b0;
  logic [47:0] cmd_exp = '0;
  int card_done = 0;
  int card_phase = 0;
  int cap_n = 0;
  int wait_n = 0;
  int sent = 0;
  logic [47:0] cap = '0;

  sd_cmd_pkg::sd_cmd_result_t exp_q[$];

  sd_cmd_top dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .sd_clk_en_i      (clk_en),
    .sd_cmd_i         (sd_cmd),
    .sd_dat0_busy_n_i (busy_n),
    .req_valid_i      (req_valid),
    .req_i            (req),
    .req_ready_o      (req_ready),
    .sd_cmd_o         (cmd_out),
    .sd_cmd_oe_o      (cmd_oe),
    .cmd_done_o       (cmd_done),
    .dat_busy_o       (dat_busy),
    .result_valid_o   (result_valid),
    .result_o         (result)
  );

  always #4 clk = ~clk;

  // Bus tick on every second clock
  always @(negedge clk) begin
    clk_en <= ~clk_en;
  end

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Serial CRC7 over the n low bits, MSB first, polynomial x^7 + x^3 + 1
  function automatic logic [6:0] ref_crc7(input logic [127:0] bits, input int n);
    logic [6:0] c;
    logic fb;
    c = '0;
    for (int i = n - 1; i >= 0; i--) begin
      fb = bits[i] ^ c[6];
      c = {c[5:0], 1'b0};
      if (fb) begin
        c = c ^ 7'h09;
      end
    end
    return c;
  endfunction

  function automatic logic [47:0] build_cmd(input logic [5:0] idx, input logic [31:0] arg);
    logic [39:0] head;
    head = {1'b0, 1'b1, idx, arg};
    return {head, ref_crc7({88'b0, head}, 40), 1'b1};
  endfunction

  // Response frame left-aligned; mode 1 flips a CRC bit, mode 2 clears the end bit
  function automatic logic [135:0] build_rsp(input logic long_rsp, input logic [119:0] payload,
                                             input int mode);
    logic [39:0] head;
    logic [6:0] crc;
    logic end_bit;
    end_bit = (mode != 2);
    if (long_rsp) begin
      crc = ref_crc7({8'b0, payload}, 120);
      if (mode == 1) begin
        crc = crc ^ 7'h01;
      end
      return {2'b00, 6'h3f, payload, crc, end_bit};
    end else begin
      head = {2'b00, payload[37:0]};
      crc = ref_crc7({88'b0, head}, 40);
      if (mode == 1) begin
        crc = crc ^ 7'h01;
      end
      return {head, crc, end_bit, 88'b0};
    end
  endfunction

  // Card model works on the falling edge after each tick
  always @(negedge clk) begin
    if (rst_n && clk_en) begin
      case (card_phase)
        0: begin
          if (cmd_oe) begin
            cap = {cap[46:0], cmd_out};
            cap_n = 1;
            card_phase = 1;
          end
        end
        1: begin
          check("sd_cmd_oe_o", {127'b0, cmd_oe}, 128'd1);
          cap = {cap[46:0], cmd_out};
          cap_n++;
          if (cap_n == 48) begin
            check("sd_cmd_o frame", {80'b0, cap}, {80'b0, cmd_exp});
            wait_n = 0;
            if (card_reply) begin
              card_phase = 2;
            end else begin
              card_done++;
              card_phase = 0;
            end
          end
        end
        2: begin
          wait_n++;
          if (wait_n == card_delay) begin
            sd_cmd <= card_frame[135];
            sent = 1;
            card_phase = 3;
          end
        end
        default: begin
          if (sent == card_len) begin
            sd_cmd <= 1'b1;
            card_done++;
            card_phase = 0;
          end else begin
            sd_cmd <= card_frame[135 - sent];
            sent++;
          end
        end
      endcase
    end
  end

  // Comparison of every result against the expected queue
  always @(negedge clk) begin
    sd_cmd_pkg::sd_cmd_result_t exp;
    if (result_valid) begin
      if (exp_q.size() == 0) begin
        $display("Result appeared when none was expected");
        errors++;
      end else begin
        exp = exp_q.pop_front();
        check("result_o.rsp", {8'b0, result.rsp}, {8'b0, exp.rsp});
        check("result_o.crc_err", {127'b0, result.crc_err}, {127'b0, exp.crc_err});
        check("result_o.end_bit_err", {127'b0, result.end_bit_err}, {127'b0, exp.end_bit_err});
        check("result_o.timeout", {127'b0, result.timeout}, {127'b0, exp.timeout});
      end
    end
  end

  // cmd_done_o follows the bus tick, so it is valid just before the rising edge
  always @(posedge clk) begin
    if (cmd_done) begin
      done_cnt++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("Errors: %0d", errors);
      $display("Something failed");
      $finish;
    end
  end

  // Modes: 0 good, 1 bad CRC, 2 bad end bit, 3 silent card, 4 late reply
  task automatic run_cmd(input logic [5:0] idx, input logic [31:0] arg,
                         input sd_cmd_pkg::rsp_type_e rt, input int mode,
                         input int delay, input int hold);
    logic [127:0] rnd;
    logic [119:0] payload;
    logic long_rsp;
    sd_cmd_pkg::sd_cmd_result_t exp;
    rnd = {$random(seed), $random(seed), $random(seed), $random(seed)};
    long_rsp = (rt == sd_cmd_pkg::RSP_136);
    payload = long_rsp ? rnd[119:0] : {82'b0, rnd[37:0]};
    card_frame = build_rsp(long_rsp, payload, mode);
    card_len = long_rsp ? 136 : 48;
    card_delay = delay;
    card_reply = (rt != sd_cmd_pkg::RSP_NONE) && (mode != 3);
    cmd_exp = build_cmd(idx, arg);
    if (rt != sd_cmd_pkg::RSP_NONE) begin
      exp = '0;
      if (mode >= 3) begin
        exp.timeout = 1'b1;
      end else begin
        exp.rsp = payload;
        exp.crc_err = (mode == 1);
        exp.end_bit_err = (mode == 2);
      end
      exp_q.push_back(exp);
    end
    if (hold > 0) begin
      busy_n = 1'b0;
    end
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    req_valid = 1'b1;
    req = '{index: idx, arg: arg, rsp_type: rt};
    @(negedge clk);
    req_valid = 1'b0;
    issued++;
    if (hold > 0) begin
      while (exp_q.size() != 0) begin
        @(negedge clk);
      end
      repeat (hold) begin
        @(negedge clk);
        check("dat_busy_o", {127'b0, dat_busy}, 128'd1);
        check("req_ready_o", {127'b0, req_ready}, 128'd0);
      end
      busy_n = 1'b1;
    end
    while (!(req_ready && (card_done == issued))) begin
      @(negedge clk);
    end
    check("cmd_done_o count", 128'(done_cnt), 128'(issued));
    check("pending results", 128'(exp_q.size()), 128'd0);
    check("dat_busy_o", {127'b0, dat_busy}, 128'd0);
    check("sd_cmd_oe_o", {127'b0, cmd_oe}, 128'd0);
  endtask

  initial begin
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) begin
      run_cmd(6'($random(seed)), $random(seed), sd_cmd_pkg::RSP_48, 0, 4, 0);
    end
    repeat (2) begin
      run_cmd(6'($random(seed)), $random(seed), sd_cmd_pkg::RSP_136, 0, 4, 0);
    end
    run_cmd(6'd13, $random(seed), sd_cmd_pkg::RSP_48, 1, 4, 0);
    run_cmd(6'd9, $random(seed), sd_cmd_pkg::RSP_136, 2, 4, 0);
    run_cmd(6'd17, $random(seed), sd_cmd_pkg::RSP_48, 3, 4, 0);
    // CMD2 reply arrives after its short window has closed
    run_cmd(6'd2, 32'h0, sd_cmd_pkg::RSP_136, 4, 8, 0);
    run_cmd(6'd7, $random(seed), sd_cmd_pkg::RSP_48_BUSY, 0, 4, 20);
    run_cmd(6'd0, 32'h0, sd_cmd_pkg::RSP_NONE, 0, 4, 0);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/sd_cmd_pkg.sv
verilog/sd_bit_counter.sv
verilog/sd_cmd_tx.sv
verilog/sd_rsp_rx.sv
verilog/sd_cmd_fsm.sv
verilog/sd_cmd_top.sv
sim/sd_cmd_asserts.sv
sim/tb_sd_cmd.sv

/* verilog/sd_bit_counter.sv */
// ****************************************
// Bus tick counter
// Saturating, with a synchronous clear
// ****************************************
`timescale 1ns/1ps

module sd_bit_counter (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     tick_i,
  input  logic                     clear_i,
  output sd_cmd_pkg::tick_count_t  count_o
);

  sd_cmd_pkg::tick_count_t count_q;

  // Clear wins over a tick in the same clock
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (tick_i && (count_q != '1)) begin
      count_q <= count_q + 7'd1;
    end
  end

  assign count_o = count_q;

endmodule

/* verilog/sd_cmd_fsm.sv */
// ****************************************
// SD command sequencing FSM
// Request, command, response window, busy
// and the idle gap before the next command
// ****************************************
`timescale 1ns/1ps

module sd_cmd_fsm (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       sd_clk_en_i,
  input  logic                       req_valid_i,
  input  sd_cmd_pkg::sd_cmd_req_t    req_i,
  output logic                       req_ready_o,
  output logic                       tx_start_o,
  input  logic                       tx_done_i,
  output logic                       rx_listen_o,
  output logic                       rx_long_o,
  input  logic                       rx_receiving_i,
  input  logic                       rx_valid_i,
  input  sd_cmd_pkg::sd_cmd_result_t rx_result_i,
  input  logic                       busy_n_i,
  output logic                       cnt_clear_o,
  input  sd_cmd_pkg::tick_count_t    ticks_i,
  output sd_cmd_pkg::sd_cmd_req_t    cmd_req_o,
  output logic                       result_valid_o,
  output sd_cmd_pkg::sd_cmd_result_t result_o,
  output logic                       cmd_done_o,
  output logic                       dat_busy_o
);

  sd_cmd_pkg::cmd_state_e  state_q;
  sd_cmd_pkg::cmd_state_e  state_d;
  sd_cmd_pkg::sd_cmd_req_t req_q;
  sd_cmd_pkg::tick_count_t rsp_limit;
  sd_cmd_pkg::tick_count_t gap_len;
  logic                    accept;

  assign accept = req_valid_i && (state_q == sd_cmd_pkg::IDLE);

  // CMD2 answers within N_ID, everything else within N_CR_MAX
  assign rsp_limit = (req_q.index == 6'd2) ? sd_cmd_pkg::N_ID : sd_cmd_pkg::N_CR_MAX;
  assign gap_len   = (req_q.rsp_type == sd_cmd_pkg::RSP_NONE) ? sd_cmd_pkg::N_CC
                                                               : sd_cmd_pkg::N_RC;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= sd_cmd_pkg::IDLE;
      req_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        req_q <= req_i;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      sd_cmd_pkg::IDLE: begin
        if (accept) begin
          state_d = sd_cmd_pkg::SEND_CMD;
        end
      end
      sd_cmd_pkg::SEND_CMD: begin
        if (tx_done_i) begin
          state_d = (req_q.rsp_type == sd_cmd_pkg::RSP_NONE) ? sd_cmd_pkg::BUS_COOLDOWN
                                                             : sd_cmd_pkg::WAIT_RSP;
        end
      end
      sd_cmd_pkg::WAIT_RSP: begin
        if (rx_receiving_i) begin
          state_d = sd_cmd_pkg::READ_RSP;
        end else if (ticks_i >= rsp_limit) begin
          state_d = sd_cmd_pkg::RSP_TIMEOUT;
        end
      end
      sd_cmd_pkg::READ_RSP: begin
        if (rx_valid_i) begin
          state_d = (req_q.rsp_type == sd_cmd_pkg::RSP_48_BUSY) ? sd_cmd_pkg::WAIT_BUSY
                                                                : sd_cmd_pkg::BUS_COOLDOWN;
        end
      end
      sd_cmd_pkg::WAIT_BUSY: begin
        // DAT0 is a card signal, sample it on bus ticks
        if (sd_clk_en_i && busy_n_i) begin
          state_d = sd_cmd_pkg::BUS_COOLDOWN;
        end
      end
      sd_cmd_pkg::BUS_COOLDOWN: begin
        if (ticks_i >= gap_len) begin
          state_d = sd_cmd_pkg::IDLE;
        end
      end
      sd_cmd_pkg::RSP_TIMEOUT: begin
        state_d = sd_cmd_pkg::IDLE;
      end
      default: begin
        state_d = sd_cmd_pkg::IDLE;
      end
    endcase
  end

  // Counter restarts whenever a timed state is entered
  assign cnt_clear_o = (state_d != state_q) &&
                       ((state_d == sd_cmd_pkg::WAIT_RSP) ||
                        (state_d == sd_cmd_pkg::BUS_COOLDOWN));

  // Listen only inside the response window
  assign rx_listen_o = (state_q == sd_cmd_pkg::WAIT_RSP) &&
                       (ticks_i >= sd_cmd_pkg::N_CR_MIN) && (ticks_i < rsp_limit);
  assign rx_long_o   = (req_q.rsp_type == sd_cmd_pkg::RSP_136);

  assign req_ready_o = (state_q == sd_cmd_pkg::IDLE);
  assign tx_start_o  = accept;
  assign cmd_req_o   = req_q;
  assign cmd_done_o  = tx_done_i && (state_q == sd_cmd_pkg::SEND_CMD);
  assign dat_busy_o  = (state_q != sd_cmd_pkg::IDLE) &&
                       (req_q.rsp_type == sd_cmd_pkg::RSP_48_BUSY);

  assign result_valid_o = rx_valid_i || (state_q == sd_cmd_pkg::RSP_TIMEOUT);

  always_comb begin
    result_o = rx_result_i;
    if (state_q == sd_cmd_pkg::RSP_TIMEOUT) begin
      result_o         = '0;
      result_o.timeout = 1'b1;
    end
  end

endmodule

/* verilog/sd_cmd_pkg.sv */
// ****************************************
// SD command engine package
// Bus timing, field types, request/result
// structs and the CRC7 step
// ****************************************
package sd_cmd_pkg;

  typedef logic [5:0]   cmd_index_t;
  typedef logic [31:0]  cmd_arg_t;
  typedef logic [6:0]   crc7_t;
  typedef logic [119:0] rsp_data_t;
  typedef logic [6:0]   tick_count_t;

  // Card timing windows, in bus ticks
  localparam tick_count_t N_CR_MIN = 7'd2;
  localparam tick_count_t N_CR_MAX = 7'd64;
  localparam tick_count_t N_ID     = 7'd5;
  localparam tick_count_t N_RC     = 7'd8;
  localparam tick_count_t N_CC     = 7'd8;

  localparam int CMD_FRAME_LEN = 48;
  localparam int CMD_HEAD_LEN  = 40;
  localparam int RSP_SHORT_LEN = 48;
  localparam int RSP_LONG_LEN  = 136;
  // Leading bits of a response that precede the payload
  localparam int RSP_SHORT_HDR = 2;
  localparam int RSP_LONG_HDR  = 8;

  typedef enum logic [1:0] {
    RSP_NONE,
    RSP_48,
    RSP_48_BUSY,
    RSP_136
  } rsp_type_e;

  typedef struct packed {
    cmd_index_t index;
    cmd_arg_t   arg;
    rsp_type_e  rsp_type;
  } sd_cmd_req_t;

  typedef struct packed {
    rsp_data_t rsp;
    logic      crc_err;
    logic      end_bit_err;
    logic      timeout;
  } sd_cmd_result_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_CMD,
    WAIT_RSP,
    READ_RSP,
    WAIT_BUSY,
    BUS_COOLDOWN,
    RSP_TIMEOUT
  } cmd_state_e;

  // One serial step of x^7 + x^3 + 1
  function automatic crc7_t crc7_next(crc7_t crc, logic din);
    logic fb;
    fb = din ^ crc[6];
    return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
  endfunction

endpackage

/* verilog/sd_cmd_top.sv */
// ****************************************
// SD host command-line engine
// FSM, tick counter, transmitter, receiver
// ****************************************
`timescale 1ns/1ps

module sd_cmd_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       sd_clk_en_i,
  input  logic                       sd_cmd_i,
  input  logic                       sd_dat0_busy_n_i,
  input  logic                       req_valid_i,
  input  sd_cmd_pkg::sd_cmd_req_t    req_i,
  output logic                       req_ready_o,
  output logic                       sd_cmd_o,
  output logic                       sd_cmd_oe_o,
  output logic                       cmd_done_o,
  output logic                       dat_busy_o,
  output logic                       result_valid_o,
  output sd_cmd_pkg::sd_cmd_result_t result_o
);

  logic                       tx_start;
  logic                       tx_done;
  logic                       rx_listen;
  logic                       rx_long;
  logic                       rx_receiving;
  logic                       rx_valid;
  logic                       cnt_clear;
  sd_cmd_pkg::sd_cmd_result_t rx_result;
  sd_cmd_pkg::tick_count_t    ticks;
  sd_cmd_pkg::sd_cmd_req_t    cmd_req;

  sd_cmd_fsm u_fsm (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .sd_clk_en_i    (sd_clk_en_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .req_ready_o    (req_ready_o),
    .tx_start_o     (tx_start),
    .tx_done_i      (tx_done),
    .rx_listen_o    (rx_listen),
    .rx_long_o      (rx_long),
    .rx_receiving_i (rx_receiving),
    .rx_valid_i     (rx_valid),
    .rx_result_i    (rx_result),
    .busy_n_i       (sd_dat0_busy_n_i),
    .cnt_clear_o    (cnt_clear),
    .ticks_i        (ticks),
    .cmd_req_o      (cmd_req),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .cmd_done_o     (cmd_done_o),
    .dat_busy_o     (dat_busy_o)
  );

  sd_bit_counter u_counter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .tick_i  (sd_clk_en_i),
    .clear_i (cnt_clear),
    .count_o (ticks)
  );

  sd_cmd_tx u_tx (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .tick_i   (sd_clk_en_i),
    .start_i  (tx_start),
    .req_i    (cmd_req),
    .cmd_o    (sd_cmd_o),
    .cmd_oe_o (sd_cmd_oe_o),
    .done_o   (tx_done)
  );

  sd_rsp_rx u_rx (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .tick_i      (sd_clk_en_i),
    .listen_i    (rx_listen),
    .long_i      (rx_long),
    .cmd_i       (sd_cmd_i),
    .receiving_o (rx_receiving),
    .valid_o     (rx_valid),
    .result_o    (rx_result)
  );

endmodule

/* verilog/sd_cmd_tx.sv */
// ****************************************
// SD command transmitter
// Shifts out the 48-bit frame MSB first,
// building the CRC7 as it goes
// ****************************************
`timescale 1ns/1ps

module sd_cmd_tx (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    tick_i,
  input  logic                    start_i,
  input  sd_cmd_pkg::sd_cmd_req_t req_i,
  output logic                    cmd_o,
  output logic                    cmd_oe_o,
  output logic                    done_o
);

  logic                  pending_q;
  logic                  busy_q;
  logic [39:0]           shift_q;
  sd_cmd_pkg::crc7_t     crc_q;
  logic [5:0]            bit_idx_q;
  logic                  cmd_q;
  logic                  oe_q;

  logic [39:0]           head;
  logic [39:0]           cur_shift;
  sd_cmd_pkg::crc7_t     cur_crc;
  logic [5:0]            cur_idx;
  logic                  tx_bit;

  // Start bit, transmission bit, index and argument
  assign head = {1'b0, 1'b1, req_i.index, req_i.arg};

  // The first bit comes straight from the request, later ones from the shifter
  assign cur_shift = pending_q ? head : shift_q;
  assign cur_crc   = pending_q ? '0 : crc_q;
  assign cur_idx   = pending_q ? '0 : bit_idx_q;

  always_comb begin
    if (cur_idx < 6'(sd_cmd_pkg::CMD_HEAD_LEN)) begin
      tx_bit = cur_shift[39];
    end else if (cur_idx < 6'(sd_cmd_pkg::CMD_FRAME_LEN - 1)) begin
      tx_bit = cur_crc[6];
    end else begin
      tx_bit = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
      busy_q    <= 1'b0;
      cmd_q     <= 1'b1;
      oe_q      <= 1'b0;
    end else if (start_i) begin
      pending_q <= 1'b1;
    end else if (tick_i && (pending_q || busy_q)) begin
      pending_q <= 1'b0;
      busy_q    <= (cur_idx != 6'(sd_cmd_pkg::CMD_FRAME_LEN - 1));
      cmd_q     <= tx_bit;
      oe_q      <= 1'b1;
      bit_idx_q <= cur_idx + 6'd1;
      if (cur_idx < 6'(sd_cmd_pkg::CMD_HEAD_LEN)) begin
        shift_q <= {cur_shift[38:0], 1'b0};
        crc_q   <= sd_cmd_pkg::crc7_next(cur_crc, tx_bit);
      end else begin
        crc_q   <= {cur_crc[5:0], 1'b0};
      end
    end else if (tick_i) begin
      // Release the line after the end bit
      cmd_q <= 1'b1;
      oe_q  <= 1'b0;
    end
  end

  assign cmd_o    = cmd_q;
  assign cmd_oe_o = oe_q;
  assign done_o   = tick_i && busy_q && (bit_idx_q == 6'(sd_cmd_pkg::CMD_FRAME_LEN - 1));

endmodule

/* verilog/sd_rsp_rx.sv */
// ****************************************
// SD response receiver
// Catches the start bit, shifts in 48 or
// 136 bits, checks CRC7 and end bit
// ****************************************
`timescale 1ns/1ps

module sd_rsp_rx (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       tick_i,
  input  logic                       listen_i,
  input  logic                       long_i,
  input  logic                       cmd_i,
  output logic                       receiving_o,
  output logic                       valid_o,
  output sd_cmd_pkg::sd_cmd_result_t result_o
);

  logic                       recv_q;
  logic                       valid_q;
  logic [7:0]                 pos_q;
  sd_cmd_pkg::crc7_t          crc_q;
  sd_cmd_pkg::crc7_t          crc_rx_q;
  sd_cmd_pkg::rsp_data_t      data_q;
  sd_cmd_pkg::sd_cmd_result_t result_q;

  logic [7:0] last_pos;
  logic [7:0] crc_pos;
  logic [7:0] data_pos;
  logic       crc_on;

  // Frame layout depends on response length
  assign last_pos = long_i ? 8'(sd_cmd_pkg::RSP_LONG_LEN - 1) : 8'(sd_cmd_pkg::RSP_SHORT_LEN - 1);
  assign crc_pos  = last_pos - 8'd7;
  assign data_pos = long_i ? 8'(sd_cmd_pkg::RSP_LONG_HDR) : 8'(sd_cmd_pkg::RSP_SHORT_HDR);

  // Long responses exclude their 8 header bits from the CRC
  assign crc_on = !long_i || (pos_q >= 8'(sd_cmd_pkg::RSP_LONG_HDR));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      recv_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (tick_i && !recv_q && listen_i && !cmd_i) begin
        recv_q <= 1'b1;
        pos_q  <= 8'd1;
        crc_q  <= '0;
        data_q <= '0;
      end else if (tick_i && recv_q) begin
        pos_q <= pos_q + 8'd1;
        if (pos_q < crc_pos) begin
          if (crc_on) begin
            crc_q <= sd_cmd_pkg::crc7_next(crc_q, cmd_i);
          end
          if (pos_q >= data_pos) begin
            data_q <= {data_q[118:0], cmd_i};
          end
        end else if (pos_q < last_pos) begin
          crc_rx_q <= {crc_rx_q[5:0], cmd_i};
        end else begin
          // End bit sampled
          recv_q               <= 1'b0;
          valid_q              <= 1'b1;
          result_q.rsp         <= data_q;
          result_q.crc_err     <= (crc_q != crc_rx_q);
          result_q.end_bit_err <= !cmd_i;
          result_q.timeout     <= 1'b0;
        end
      end
    end
  end

  assign receiving_o = recv_q;
  assign valid_o     = valid_q;
  assign result_o    = result_q;

endmodule
